// ==== bp_pkg.sv ====
`default_nettype none

// ******************************************************************
// shared types and address map of the backplane
// ******************************************************************
package bp_pkg;

   typedef logic [15:0] word_t;   // bus address / data word
   typedef logic [1:0]  sel_t;    // byte lanes, bit 1 = high byte

   // who drives the shared bus
   typedef enum logic [1:0] {
      OWN_CPU = 2'd0,             // default owner
      OWN_RK  = 2'd1,             // RK11 disk DMA
      OWN_MY  = 2'd2              // MY floppy DMA
   } bus_owner_e;

   // who talks to the sd card
   typedef enum logic [2:0] {
      SD_NONE = 3'd0,
      SD_RK   = 3'd1,
      SD_DW   = 3'd2,
      SD_DX   = 3'd3,
      SD_MY   = 3'd4
   } sd_owner_e;

   // I/O page starts at 160000 octal, everything below is main RAM
   localparam word_t IO_PAGE_BASE = 16'o160000;
   localparam logic  SD_IDLE_LINE = 1'b1;   // mosi/cs level with no owner

endpackage

`default_nettype wire

// ==== wb_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// shared wishbone bus between master mux, decoder and RAM
interface wb_bus_if import bp_pkg::*; ();

   word_t adr;     // byte address
   word_t dat_w;   // master -> slave data
   word_t dat_r;   // slave -> master data
   logic  cyc;     // bus cycle in progress
   logic  stb;     // transfer strobe
   logic  we;      // 1 = write
   sel_t  sel;     // byte lanes
   logic  ack;     // transfer done

   // bus master side, fed by the owner mux
   modport master (output adr, dat_w, cyc, stb, we, sel,
                   input  ack);

   // address decoder side, returns data and ack
   modport slave (input  adr, cyc, stb,
                  output dat_r, ack);

   // passive view for the RAM array
   modport monitor (input adr, dat_w, we, sel);

endinterface

`default_nettype wire

// ==== bus_master_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

// DMA/CPU arbiter and master signal switch
module bus_master_mux import bp_pkg::*; (
   input  logic  wb_clk,
   input  logic  rst_i,
   // cpu master
   input  word_t cpu_adr_i,
   input  word_t cpu_dat_i,
   input  logic  cpu_cyc_i,
   input  logic  cpu_stb_i,
   input  logic  cpu_we_i,
   input  sel_t  cpu_sel_i,
   output logic  cpu_gnt_o,   // 0 = cpu stalls waiting for ack
   output logic  cpu_ack_o,
   // RK11 DMA
   input  logic  rk_req_i,
   input  word_t rk_adr_i,
   input  word_t rk_dat_i,
   input  logic  rk_stb_i,
   input  logic  rk_we_i,
   output logic  rk_gnt_o,
   output logic  rk_ack_o,
   // MY DMA
   input  logic  my_req_i,
   input  word_t my_adr_i,
   input  word_t my_dat_i,
   input  logic  my_stb_i,
   input  logic  my_we_i,
   output logic  my_gnt_o,
   output logic  my_ack_o,
   // shared bus
   wb_bus_if.master bus
);

   bus_owner_e owner_q;   // current bus owner

   //*********************************************************************
   // owner register
   //*********************************************************************
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         owner_q <= OWN_CPU;
      end else if (!bus.cyc) begin           // switch only between cycles
         if (rk_req_i)      owner_q <= OWN_RK;   // RK wins
         else if (my_req_i) owner_q <= OWN_MY;
         else               owner_q <= OWN_CPU;  // no DMA, back to cpu
      end
   end

   assign cpu_gnt_o = (owner_q == OWN_CPU);
   assign rk_gnt_o  = (owner_q == OWN_RK);
   assign my_gnt_o  = (owner_q == OWN_MY);

   // ack only reaches the master that owns the bus
   assign cpu_ack_o = cpu_gnt_o & bus.ack;
   assign rk_ack_o  = rk_gnt_o & bus.ack;
   assign my_ack_o  = my_gnt_o & bus.ack;

   //*********************************************************************
   // master signal switch
   //*********************************************************************
   always_comb begin
      case (owner_q)
         OWN_RK: begin
            bus.adr   = rk_adr_i;
            bus.dat_w = rk_dat_i;
            bus.cyc   = rk_req_i;   // request doubles as cyc
            bus.stb   = rk_stb_i;
            bus.we    = rk_we_i;
            bus.sel   = 2'b11;      // DMA is always word wide
         end
         OWN_MY: begin
            bus.adr   = my_adr_i;
            bus.dat_w = my_dat_i;
            bus.cyc   = my_req_i;
            bus.stb   = my_stb_i;
            bus.we    = my_we_i;
            bus.sel   = 2'b11;
         end
         default: begin             // cpu
            bus.adr   = cpu_adr_i;
            bus.dat_w = cpu_dat_i;
            bus.cyc   = cpu_cyc_i;
            bus.stb   = cpu_stb_i;
            bus.we    = cpu_we_i;
            bus.sel   = cpu_sel_i;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== io_page_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

// address decode into RAM / I/O page, ack collection, read data mux
module io_page_decoder import bp_pkg::*; (
   wb_bus_if.slave bus,
   // RAM side
   input  word_t ram_dat_i,
   input  logic  ram_ack_i,
   output logic  ram_stb_o,
   // external I/O page
   input  word_t io_dat_i,
   input  logic  io_ack_i,
   output logic  io_stb_o
);

   logic bus_stb;   // stb qualified by cyc
   logic io_hit;    // address lies in the I/O page

   assign bus_stb = bus.cyc & bus.stb;
   assign io_hit  = (bus.adr >= IO_PAGE_BASE);

   //*********************************************************************
   // strobes
   //*********************************************************************
   assign ram_stb_o = bus_stb & ~io_hit;   // 000000-157777
   assign io_stb_o  = bus_stb & io_hit;    // 160000-177777

   // acks just ORed together
   // only the strobed target can answer
   assign bus.ack = ram_ack_i | io_ack_i;

   // data from whichever target is strobed
   assign bus.dat_r = (ram_stb_o ? ram_dat_i : 16'o0)
                    | (io_stb_o  ? io_dat_i  : 16'o0);

endmodule

`default_nettype wire

// ==== wb_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

// main RAM with byte lanes and fixed 2 cycle ack
module wb_ram import bp_pkg::*; #(
   parameter int RAM_ADDR_BITS = 13   // word address bits
) (
   input  logic  wb_clk,
   input  logic  rst_i,
   input  logic  ram_stb_i,           // decoded RAM strobe
   wb_bus_if.monitor bus,
   output word_t ram_dat_o,
   output logic  ram_ack_o
);

   word_t mem [2**RAM_ADDR_BITS];     // word array
   logic [RAM_ADDR_BITS-1:0] word_idx;
   logic [1:0] ack_dly;               // ack delay line
   word_t rd_q;                       // registered read word

   // byte bit dropped, upper bits alias
   assign word_idx = bus.adr[RAM_ADDR_BITS:1];

   //*********************************************************************
   // ack delay
   //*********************************************************************
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack_dly <= 2'b00;
      end else begin
         // restart after each ack so back to back strobes wait again
         ack_dly[0] <= ram_stb_i & ~(ack_dly[0] | ack_dly[1]);
         ack_dly[1] <= ram_stb_i & ack_dly[0];   // cleared if stb drops
      end
   end

   assign ram_ack_o = ram_stb_i & ack_dly[1];

   // array access
   always_ff @(posedge wb_clk) begin
      rd_q <= mem[word_idx];                     // reads are always full word
      if (ram_ack_o & bus.we) begin
         if (bus.sel[0]) mem[word_idx][7:0]  <= bus.dat_w[7:0];    // low byte
         if (bus.sel[1]) mem[word_idx][15:8] <= bus.dat_w[15:8];   // high byte
      end
   end

   assign ram_dat_o = rd_q;

endmodule

`default_nettype wire

// ==== sdcard_dispatcher.sv ====
`timescale 1ns/10ps
`default_nettype none

// sd card ownership between the four disk controllers
module sdcard_dispatcher import bp_pkg::*; (
   input  logic wb_clk,
   input  logic rst_i,
   // access requests
   input  logic rk_sdreq_i,
   input  logic dw_sdreq_i,
   input  logic dx_sdreq_i,
   input  logic my_sdreq_i,
   // spi lines from each controller
   input  logic rk_mosi_i,
   input  logic dw_mosi_i,
   input  logic dx_mosi_i,
   input  logic my_mosi_i,
   input  logic rk_cs_i,
   input  logic dw_cs_i,
   input  logic dx_cs_i,
   input  logic my_cs_i,
   // grants
   output logic rk_sdack_o,
   output logic dw_sdack_o,
   output logic dx_sdack_o,
   output logic my_sdack_o,
   // card side
   output logic sdcard_mosi_o,
   output logic sdcard_cs_o
);

   sd_owner_e owner_q;   // current card owner

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         owner_q <= SD_NONE;
      end else begin
         case (owner_q)
            SD_NONE: begin                    // idle, look for a requester
               if (rk_sdreq_i)      owner_q <= SD_RK;
               else if (dw_sdreq_i) owner_q <= SD_DW;
               else if (dx_sdreq_i) owner_q <= SD_DX;
               else if (my_sdreq_i) owner_q <= SD_MY;
            end
            // busy until the owner lets go
            SD_RK:   if (!rk_sdreq_i) owner_q <= SD_NONE;
            SD_DW:   if (!dw_sdreq_i) owner_q <= SD_NONE;
            SD_DX:   if (!dx_sdreq_i) owner_q <= SD_NONE;
            SD_MY:   if (!my_sdreq_i) owner_q <= SD_NONE;
            default: owner_q <= SD_NONE;
         endcase
      end
   end

   assign rk_sdack_o = (owner_q == SD_RK);
   assign dw_sdack_o = (owner_q == SD_DW);
   assign dx_sdack_o = (owner_q == SD_DX);
   assign my_sdack_o = (owner_q == SD_MY);

   //*********************************************************************
   // card line mux
   //*********************************************************************
   always_comb begin
      case (owner_q)
         SD_RK:   begin sdcard_mosi_o = rk_mosi_i; sdcard_cs_o = rk_cs_i; end
         SD_DW:   begin sdcard_mosi_o = dw_mosi_i; sdcard_cs_o = dw_cs_i; end
         SD_DX:   begin sdcard_mosi_o = dx_mosi_i; sdcard_cs_o = dx_cs_i; end
         SD_MY:   begin sdcard_mosi_o = my_mosi_i; sdcard_cs_o = my_cs_i; end
         default: begin                          // nobody, card deselected
            sdcard_mosi_o = SD_IDLE_LINE;
            sdcard_cs_o   = SD_IDLE_LINE;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== backplane_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// backplane with shared wishbone bus, RAM, I/O page port and sd dispatcher
module backplane_top import bp_pkg::*; #(
   parameter int RAM_ADDR_BITS = 13
) (
   input  logic  wb_clk,
   input  logic  rst_i,
   // cpu master
   input  word_t cpu_adr_i,
   input  word_t cpu_dat_i,
   input  logic  cpu_cyc_i,
   input  logic  cpu_stb_i,
   input  logic  cpu_we_i,
   input  sel_t  cpu_sel_i,
   output word_t cpu_dat_o,
   output logic  cpu_ack_o,
   output logic  cpu_gnt_o,
   // RK11 DMA master
   input  logic  rk_req_i,
   input  word_t rk_adr_i,
   input  word_t rk_dat_i,
   input  logic  rk_stb_i,
   input  logic  rk_we_i,
   output logic  rk_gnt_o,
   output logic  rk_ack_o,
   // MY DMA master
   input  logic  my_req_i,
   input  word_t my_adr_i,
   input  word_t my_dat_i,
   input  logic  my_stb_i,
   input  logic  my_we_i,
   output logic  my_gnt_o,
   output logic  my_ack_o,
   // I/O page port
   output word_t io_adr_o,
   output word_t io_dat_o,
   output logic  io_we_o,
   output logic  io_stb_o,
   input  word_t io_dat_i,
   input  logic  io_ack_i,
   // sd card controllers
   input  logic  rk_sdreq_i,
   input  logic  rk_mosi_i,
   input  logic  rk_cs_i,
   output logic  rk_sdack_o,
   input  logic  dw_sdreq_i,
   input  logic  dw_mosi_i,
   input  logic  dw_cs_i,
   output logic  dw_sdack_o,
   input  logic  dx_sdreq_i,
   input  logic  dx_mosi_i,
   input  logic  dx_cs_i,
   output logic  dx_sdack_o,
   input  logic  my_sdreq_i,
   input  logic  my_mosi_i,
   input  logic  my_cs_i,
   output logic  my_sdack_o,
   // card
   output logic  sdcard_mosi_o,
   output logic  sdcard_cs_o
);

   wb_bus_if bus ();   // shared bus

   logic  ram_stb;     // decoded RAM strobe
   logic  ram_ack;
   word_t ram_dat;

   //*********************************************************************
   // bus masters
   //*********************************************************************
   bus_master_mux bus_master_mux_inst (
      .wb_clk, .rst_i,
      .cpu_adr_i, .cpu_dat_i, .cpu_cyc_i, .cpu_stb_i, .cpu_we_i, .cpu_sel_i,
      .cpu_gnt_o, .cpu_ack_o,
      .rk_req_i, .rk_adr_i, .rk_dat_i, .rk_stb_i, .rk_we_i, .rk_gnt_o, .rk_ack_o,
      .my_req_i, .my_adr_i, .my_dat_i, .my_stb_i, .my_we_i, .my_gnt_o, .my_ack_o,
      .bus (bus)
   );

   // read data goes back to the cpu directly
   assign cpu_dat_o = bus.dat_r;

   //*********************************************************************
   // slaves
   //*********************************************************************
   io_page_decoder io_page_decoder_inst (
      .bus       (bus),
      .ram_dat_i (ram_dat),
      .ram_ack_i (ram_ack),
      .ram_stb_o (ram_stb),
      .io_dat_i, .io_ack_i, .io_stb_o
   );

   wb_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) wb_ram_inst (
      .wb_clk, .rst_i,
      .ram_stb_i (ram_stb),
      .bus       (bus),
      .ram_dat_o (ram_dat),
      .ram_ack_o (ram_ack)
   );

   // I/O page sees the raw bus
   assign io_adr_o = bus.adr;
   assign io_dat_o = bus.dat_w;
   assign io_we_o  = bus.we;

   // sd card access
   sdcard_dispatcher sdcard_dispatcher_inst (
      .wb_clk, .rst_i,
      .rk_sdreq_i, .dw_sdreq_i, .dx_sdreq_i, .my_sdreq_i,
      .rk_mosi_i, .dw_mosi_i, .dx_mosi_i, .my_mosi_i,
      .rk_cs_i, .dw_cs_i, .dx_cs_i, .my_cs_i,
      .rk_sdack_o, .dw_sdack_o, .dx_sdack_o, .my_sdack_o,
      .sdcard_mosi_o, .sdcard_cs_o
   );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

// free running testbench clock
module tb_clkgen #(
   parameter int PERIOD_NS = 4   // full period
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;   // 50 % duty
   end

endmodule

`default_nettype wire

// ==== tb_backplane.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_backplane import bp_pkg::*; ();

   localparam int CLK_PERIOD     = 4;
   localparam int RAM_ADDR_BITS  = 13;
   localparam int REGION_WORDS   = 16;                // RAM words under test
   // I/O page addresses would land on these words if decoded as RAM
   localparam word_t REGION_BASE = word_t'(IO_PAGE_BASE % (2 ** (RAM_ADDR_BITS + 1)));
   localparam int RAM_ACK_LAT    = 2;                 // first strobe cycle -> ack cycle
   localparam int NUM_TESTS      = 5;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;

   logic  wb_clk;
   logic  rst_i     = 1'b1;
   // cpu master
   word_t cpu_adr_i = '0;
   word_t cpu_dat_i = '0;
   logic  cpu_cyc_i = 1'b0;
   logic  cpu_stb_i = 1'b0;
   logic  cpu_we_i  = 1'b0;
   sel_t  cpu_sel_i = '0;
   word_t cpu_dat_o;
   logic  cpu_ack_o, cpu_gnt_o;
   // DMA masters
   logic  rk_req_i = 1'b0, rk_stb_i = 1'b0, rk_we_i = 1'b0;
   word_t rk_adr_i = '0, rk_dat_i = '0;
   logic  rk_gnt_o, rk_ack_o;
   logic  my_req_i = 1'b0, my_stb_i = 1'b0, my_we_i = 1'b0;
   word_t my_adr_i = '0, my_dat_i = '0;
   logic  my_gnt_o, my_ack_o;
   // I/O page port
   word_t io_adr_o, io_dat_o;
   logic  io_we_o, io_stb_o;
   word_t io_dat_i = '0;
   logic  io_ack_i = 1'b0;
   // sd controllers from bit 0 rk up to bit 3 my
   logic [3:0] sd_req  = '0;
   logic [3:0] sd_mosi = '0;
   logic [3:0] sd_cs   = '0;
   wire  [3:0] sd_ack;
   logic       sdcard_mosi_o, sdcard_cs_o;

   word_t       model_mem [REGION_WORDS];   // expected RAM contents
   logic [31:0] rng = 32'd62;
   int          errors, test_errors, failed_tests;
   // I/O responder
   int          io_delay;                   // wait states before ack
   word_t       io_rdata;                   // data returned on reads
   int          io_wait, io_acks;
   word_t       io_seen_adr, io_seen_dat;
   logic        io_seen_we;

   tb_clkgen #(.PERIOD_NS(CLK_PERIOD)) tb_clkgen_inst (.clk_o(wb_clk));

   backplane_top #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) backplane_top_inst (
      .rk_sdreq_i (sd_req[0]),  .rk_mosi_i (sd_mosi[0]), .rk_cs_i (sd_cs[0]),
      .dw_sdreq_i (sd_req[1]),  .dw_mosi_i (sd_mosi[1]), .dw_cs_i (sd_cs[1]),
      .dx_sdreq_i (sd_req[2]),  .dx_mosi_i (sd_mosi[2]), .dx_cs_i (sd_cs[2]),
      .my_sdreq_i (sd_req[3]),  .my_mosi_i (sd_mosi[3]), .my_cs_i (sd_cs[3]),
      .rk_sdack_o (sd_ack[0]),  .dw_sdack_o (sd_ack[1]),
      .dx_sdack_o (sd_ack[2]),  .my_sdack_o (sd_ack[3]),
      .*
   );

   //*********************************************************************
   // helpers
   //*********************************************************************
   function automatic logic [31:0] next_rand();   // xorshift32
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   // byte lane merge per bus rule with bit 0 as low byte
   function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input sel_t sel);
      word_t res;
      res = old_w;
      if (sel[0]) res[7:0] = new_w[7:0];
      if (sel[1]) res[15:8] = new_w[15:8];
      return res;
   endfunction

   // byte address of test word k
   function automatic word_t ram_adr(input int k);
      return REGION_BASE + word_t'(2 * k);
   endfunction

   function automatic logic dma_gnt(input int m);   // 0 rk, 1 my
      return (m == 0) ? rk_gnt_o : my_gnt_o;
   endfunction

   task automatic report_mismatch(input string sig, input word_t exp, input word_t got);
      $display("ERR t=%0t %s: expected %h, got %h", $time, sig, exp, got);
      test_errors++;
   endtask

   task automatic report_failure(input string what);
      $display("t=%0t %s", $time, what);
      test_errors++;
   endtask

   task automatic end_test(input int num, input string name);
      if (test_errors == 0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, test_errors);
         failed_tests++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   // one classic cycle where lat counts cycles from first strobe to ack
   task automatic cpu_access(input word_t adr, input word_t dat, input logic we,
                             input sel_t sel, output word_t rdat, output int lat);
      int cycles;
      cycles = 0;
      @(posedge wb_clk);
      while (!cpu_gnt_o) @(posedge wb_clk);   // bus still with a DMA master
      cpu_adr_i <= adr;
      cpu_dat_i <= dat;
      cpu_we_i  <= we;
      cpu_sel_i <= sel;
      cpu_cyc_i <= 1'b1;
      cpu_stb_i <= 1'b1;
      do begin
         @(posedge wb_clk);
         cycles++;
      end while (!cpu_ack_o);
      rdat = cpu_dat_o;
      lat  = cycles - 1;
      cpu_cyc_i <= 1'b0;
      cpu_stb_i <= 1'b0;
      cpu_we_i  <= 1'b0;
      cpu_sel_i <= 2'b00;                     // no lanes while idle
   endtask

   task automatic dma_write(input int m, input word_t adr, input word_t dat);
      @(posedge wb_clk);
      if (m == 0) begin
         rk_adr_i <= adr;
         rk_dat_i <= dat;
         rk_we_i  <= 1'b1;
         rk_stb_i <= 1'b1;
      end else begin
         my_adr_i <= adr;
         my_dat_i <= dat;
         my_we_i  <= 1'b1;
         my_stb_i <= 1'b1;
      end
      do @(posedge wb_clk); while (!((m == 0) ? rk_ack_o : my_ack_o));
      rk_stb_i <= 1'b0;
      rk_we_i  <= 1'b0;
      my_stb_i <= 1'b0;
      my_we_i  <= 1'b0;
   endtask

   task automatic check_region();   // read back every test word
      word_t rd;
      int    lat;
      for (int i = 0; i < REGION_WORDS; i++) begin
         cpu_access(ram_adr(i), 16'h0000, 1'b0, 2'b11, rd, lat);
         if (rd !== model_mem[i]) report_mismatch("cpu_dat_o", model_mem[i], rd);
         if (lat != RAM_ACK_LAT)
            report_mismatch("cpu_ack_o latency", word_t'(RAM_ACK_LAT), word_t'(lat));
      end
   endtask

   //*********************************************************************
   // I/O page responder
   //*********************************************************************
   always @(posedge wb_clk) begin
      if (rst_i) begin
         io_ack_i <= 1'b0;
         io_wait = 0;
      end else if (io_ack_i) begin
         io_ack_i <= 1'b0;                  // single cycle ack
      end else if (io_stb_o) begin
         if (io_wait >= io_delay) begin
            io_ack_i <= 1'b1;
            io_dat_i <= io_rdata;
            io_seen_adr = io_adr_o;         // remember what the port saw
            io_seen_dat = io_dat_o;
            io_seen_we  = io_we_o;
            io_acks++;
            io_wait = 0;
         end else begin
            io_wait++;
         end
      end
   end

   // watchdog
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run stopped", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

   //*********************************************************************
   // test sequence
   //*********************************************************************
   initial begin
      word_t       rd, adr;
      logic        we, exp_mosi, exp_cs;
      int          lat, k, acks_before, sd_owner;
      logic [31:0] r;
      logic [3:0]  nreq, exp_ack;
      int          dma_idx[$];

      repeat (4) @(posedge wb_clk);
      rst_i <= 1'b0;

      // test 1 fills full words then byte writes and reads back
      acks_before = io_acks;
      for (int i = 0; i < REGION_WORDS; i++) begin
         r = next_rand();
         cpu_access(ram_adr(i), r[15:0], 1'b1, 2'b11, rd, lat);
         model_mem[i] = r[15:0];
         if (lat != RAM_ACK_LAT)
            report_mismatch("cpu_ack_o latency", word_t'(RAM_ACK_LAT), word_t'(lat));
      end
      repeat (24) begin
         r = next_rand();
         k = int'(r[19:16]);
         cpu_access(ram_adr(k), r[15:0], 1'b1, r[21:20], rd, lat);
         model_mem[k] = merge_lanes(model_mem[k], r[15:0], r[21:20]);
         if (lat != RAM_ACK_LAT)
            report_mismatch("cpu_ack_o latency", word_t'(RAM_ACK_LAT), word_t'(lat));
      end
      check_region();
      if (io_acks != acks_before) report_failure("I/O port answered a RAM access");
      end_test(1, "cpu ram access");

      // test 2 sends I/O page accesses out the port and leaves RAM alone
      repeat (12) begin
         r = next_rand();
         adr      = IO_PAGE_BASE | ram_adr(int'(r[3:0]));   // aliases a test word
         we       = r[16];
         io_delay = int'(r[19:17]) % 6;
         r = next_rand();
         io_rdata = r[31:16];
         acks_before = io_acks;
         cpu_access(adr, r[15:0], we, 2'b11, rd, lat);
         if (io_acks != acks_before + 1) report_failure("I/O access never reached the port");
         if (io_seen_adr !== adr) report_mismatch("io_adr_o", adr, io_seen_adr);
         if (io_seen_we !== we) report_mismatch("io_we_o", word_t'(we), word_t'(io_seen_we));
         if (we && io_seen_dat !== r[15:0]) report_mismatch("io_dat_o", r[15:0], io_seen_dat);
         if (!we && rd !== io_rdata) report_mismatch("cpu_dat_o", io_rdata, rd);
      end
      check_region();
      end_test(2, "io page routing");

      // test 3 lets each DMA master take the bus in turn
      for (int m = 0; m < 2; m++) begin
         dma_idx.delete();
         @(posedge wb_clk);
         if (m == 0) rk_req_i <= 1'b1;
         else        my_req_i <= 1'b1;
         do @(posedge wb_clk); while (!dma_gnt(m));
         if (cpu_gnt_o) report_failure("cpu_gnt_o still high with a DMA master granted");
         repeat (4) begin
            r = next_rand();
            k = int'(r[19:16]);
            dma_write(m, ram_adr(k), r[15:0]);
            model_mem[k] = r[15:0];           // word wide
            dma_idx.push_back(k);
         end
         @(posedge wb_clk);
         rk_req_i <= 1'b0;
         my_req_i <= 1'b0;
         foreach (dma_idx[j]) begin
            cpu_access(ram_adr(dma_idx[j]), 16'h0000, 1'b0, 2'b11, rd, lat);
            if (rd !== model_mem[dma_idx[j]])
               report_mismatch("cpu_dat_o", model_mem[dma_idx[j]], rd);
         end
      end
      end_test(3, "dma ownership");

      // test 4 has RK beat MY
      @(posedge wb_clk);
      rk_req_i <= 1'b1;
      my_req_i <= 1'b1;
      do @(posedge wb_clk); while (!rk_gnt_o && !my_gnt_o);
      if (!rk_gnt_o || my_gnt_o) report_failure("MY won the bus over RK");
      r = next_rand();
      k = int'(r[19:16]);
      dma_write(0, ram_adr(k), r[15:0]);
      model_mem[k] = r[15:0];
      repeat (3) begin
         @(posedge wb_clk);
         if (my_gnt_o) report_failure("MY granted while RK still requests");
      end
      rk_req_i <= 1'b0;
      do @(posedge wb_clk); while (!my_gnt_o);   // MY next
      my_req_i <= 1'b0;
      cpu_access(ram_adr(k), 16'h0000, 1'b0, 2'b11, rd, lat);
      if (rd !== model_mem[k]) report_mismatch("cpu_dat_o", model_mem[k], rd);
      end_test(4, "dma priority");

      // test 5 runs sticky random requests against an owner model
      sd_owner = 0;                              // 0 none then 1 rk up to 4 my
      repeat (150) begin
         @(posedge wb_clk);
         exp_ack  = (sd_owner == 0) ? 4'b0000 : 4'b0001 << (sd_owner - 1);
         exp_mosi = (sd_owner == 0) ? SD_IDLE_LINE : sd_mosi[sd_owner - 1];
         exp_cs   = (sd_owner == 0) ? SD_IDLE_LINE : sd_cs[sd_owner - 1];
         if (sd_ack !== exp_ack) report_mismatch("sd_ack", word_t'(exp_ack), word_t'(sd_ack));
         if (sdcard_mosi_o !== exp_mosi)
            report_mismatch("sdcard_mosi_o", word_t'(exp_mosi), word_t'(sdcard_mosi_o));
         if (sdcard_cs_o !== exp_cs)
            report_mismatch("sdcard_cs_o", word_t'(exp_cs), word_t'(sdcard_cs_o));
         if (sd_owner == 0) begin                // idle so lowest index wins
            for (int i = 3; i >= 0; i--) begin
               if (sd_req[i]) sd_owner = i + 1;
            end
         end else if (!sd_req[sd_owner - 1]) begin
            sd_owner = 0;                        // owner let go
         end
         r = next_rand();
         nreq = sd_req;
         for (int i = 0; i < 4; i++) begin
            if (r[3*i +: 3] == 3'd0) nreq[i] = ~nreq[i];   // 1 in 8 flips
         end
         sd_req  <= nreq;
         sd_mosi <= r[15:12];
         sd_cs   <= r[19:16];
      end
      sd_req <= 4'b0000;
      end_test(5, "sd dispatcher");

      $display("tests run %0d, tests with errors %0d, total errors %0d",
               NUM_TESTS, failed_tests, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
bp_pkg.sv
wb_bus_if.sv
bus_master_mux.sv
io_page_decoder.sv
wb_ram.sv
sdcard_dispatcher.sv
backplane_top.sv
tb_clkgen.sv
tb_backplane.sv

// ==== Makefile ====
TOP := tb_backplane

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean
